//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = add_unit_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "Test passed"; \
	else echo "Test failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/add_unit_top.sv
// Pipelined significand adder unit
`timescale 1ns/1ns
`default_nettype none

module add_unit_top #(
	parameter int WIDTH = alu_pkg::WIDTH_DEFAULT
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  alu_pkg::add_req_t in_req,
	output logic              out_valid,
	output alu_pkg::add_res_t out_res
);

	// Request stage outputs
	logic              req_valid;
	alu_pkg::add_req_t req_q;

	// Combinational adder result
	alu_pkg::add_res_t res_d;

	// Struct fields are sized by the package width
	if (WIDTH != alu_pkg::WIDTH_DEFAULT) begin : g_width_check
		$error("add_unit_top WIDTH must equal alu_pkg::WIDTH_DEFAULT");
	end

	// Cycle 1
	pipe_stage #(
		.payload_t(alu_pkg::add_req_t)
	) req_stage_i (
		.clk      (clk),
		.rst      (rst),
		.valid_in (in_valid),
		.data_in  (in_req),
		.valid_out(req_valid),
		.data_out (req_q)
	);

	adder #(
		.WIDTH(WIDTH)
	) adder_i (
		.req(req_q),
		.res(res_d)
	);

	// Cycle 2
	pipe_stage #(
		.payload_t(alu_pkg::add_res_t)
	) res_stage_i (
		.clk      (clk),
		.rst      (rst),
		.valid_in (req_valid),
		.data_in  (res_d),
		.valid_out(out_valid),
		.data_out (out_res)
	);

endmodule

`default_nettype wire

//--- logic/adder.sv
// Prefix adder with flags
`timescale 1ns/1ns
`default_nettype none

module adder #(
	parameter int WIDTH = 28
) (
	input  alu_pkg::add_req_t req,
	output alu_pkg::add_res_t res
);

	// Operands as seen by the adder core
	logic [WIDTH-1:0] a_op;
	logic [WIDTH-1:0] b_op;
	logic             cin_op;

	// Per-bit propagate and generate
	logic [WIDTH-1:0] p;
	logic [WIDTH-1:0] g;

	// Tree leaves, shifted up one place behind the carry-in
	prefix_pkg::gp_t [WIDTH-1:0] gp;

	// Carry into each operand bit
	logic [WIDTH-1:0] carry;

	logic [WIDTH-1:0] sum;
	logic             cout;

	// Operand preparation
	always_comb begin
		a_op   = req.a;
		b_op   = req.b;
		cin_op = 1'b0;
		case (req.op)
			alu_pkg::OP_SUB: begin
				// Two's complement of b
				b_op   = ~req.b;
				cin_op = 1'b1;
			end
			alu_pkg::OP_ADC: begin
				cin_op = req.cin;
			end
			default: begin
				// Add and the reserved code
				cin_op = 1'b0;
			end
		endcase
	end

	// Pre-computation
	always_comb begin
		for (int k = 0; k < WIDTH; k++) begin
			{g[k], p[k]} = prefix_pkg::leaf_cell(a_op[k], b_op[k]);
		end
	end

	// Entry 0 carries cin in, with no propagate through it
	always_comb begin
		gp[0] = '{g: cin_op, p: 1'b0};
		for (int k = 1; k < WIDTH; k++) begin
			gp[k] = '{g: g[k-1], p: p[k-1]};
		end
	end

	ladner_fischer #(
		.WIDTH(WIDTH)
	) prefix_tree (
		.gp_in(gp),
		.carry(carry)
	);

	// Post-computation
	assign sum  = p ^ carry;
	assign cout = g[WIDTH-1] | (p[WIDTH-1] & carry[WIDTH-1]);

	assign res.sum      = sum;
	assign res.cout     = cout;
	assign res.zero     = ~|sum;
	assign res.negative = sum[WIDTH-1];
	// Carry into the sign bit disagrees with carry out of it
	assign res.overflow = carry[WIDTH-1] ^ cout;

endmodule

`default_nettype wire

//--- logic/alu_pkg.sv
// Significand adder request and result types
`default_nettype none

package alu_pkg;

	// Operand width of the significand datapath
	localparam int WIDTH_DEFAULT = 28;

	// Operation codes
	// Code 2'b11 is reserved and executes as an add
	typedef enum logic [1:0] {
		OP_ADD = 2'b00,
		OP_SUB = 2'b01,
		OP_ADC = 2'b10
	} op_t;

	// One request into the adder unit
	typedef struct packed {
		op_t                      op;
		logic [WIDTH_DEFAULT-1:0] a;
		logic [WIDTH_DEFAULT-1:0] b;
		// Only looked at by OP_ADC
		logic                     cin;
	} add_req_t;

	// One result out of the adder unit
	typedef struct packed {
		logic [WIDTH_DEFAULT-1:0] sum;
		// Carry out of the top bit
		logic                     cout;
		// Sum is all zeros
		logic                     zero;
		// Top bit of the sum
		logic                     negative;
		// Signed overflow
		logic                     overflow;
	} add_res_t;

endpackage

`default_nettype wire

//--- logic/ladner_fischer.sv
// Ladner-Fischer carry tree
`timescale 1ns/1ns
`default_nettype none

module ladner_fischer #(
	parameter int WIDTH = 28
) (
	// Entry 0 holds the carry-in as its generate
	input  prefix_pkg::gp_t [WIDTH-1:0] gp_in,
	// Bit k is the group generate of entries k down to 0
	output logic            [WIDTH-1:0] carry
);

	// Number of doubling stages on the odd positions
	localparam int LEVELS = $clog2(WIDTH);

	// Group values after each stage, stage 0 is the input
	wire prefix_pkg::gp_t lvl [0:LEVELS][0:WIDTH-1];

	genvar l;
	genvar i;

	generate
		for (i = 0; i < WIDTH; i++) begin : g_leaf
			assign lvl[0][i] = gp_in[i];
		end

		// Sklansky-style doubling restricted to odd positions
		for (l = 1; l <= LEVELS; l++) begin : g_level
			for (i = 0; i < WIDTH; i++) begin : g_pos
				// Half block size at this stage
				localparam int HALF = 1 << (l - 1);
				// Top of the lower half of this block
				localparam int LOW = (i / HALF) * HALF - 1;
				// First position of the whole block
				localparam int BASE = (i / (2 * HALF)) * (2 * HALF);

				if ((i % 2 == 1) && ((i / HALF) % 2 == 1)) begin : g_cell
					if (BASE == 0) begin : g_grey
						// Span covers entry 0 whose propagate is zero
						assign lvl[l][i] = '{
							g: prefix_pkg::grey_cell(lvl[l-1][i], lvl[l-1][LOW]),
							p: 1'b0
						};
					end else begin : g_black
						assign lvl[l][i] = prefix_pkg::black_cell(lvl[l-1][i],
							lvl[l-1][LOW]);
					end
				end else begin : g_pass
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end

		// Odd positions are complete after the last stage
		// Even positions take one extra grey cell from their odd neighbour
		for (i = 0; i < WIDTH; i++) begin : g_carry
			if ((i == 0) || (i % 2 == 1)) begin : g_direct
				assign carry[i] = lvl[LEVELS][i].g;
			end else begin : g_even
				assign carry[i] = prefix_pkg::grey_cell(lvl[LEVELS][i],
					lvl[LEVELS][i-1]);
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- logic/pipe_stage.sv
// Valid-qualified pipeline register
`timescale 1ns/1ns
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     valid_in,
	input  payload_t data_in,
	output logic     valid_out,
	output payload_t data_out
);

	// Valid strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// Payload loads every cycle, qualified downstream by valid_out
	always_ff @(posedge clk) begin
		data_out <= data_in;
	end

endmodule

`default_nettype wire

//--- logic/prefix_pkg.sv
// Carry-prefix network cells
`default_nettype none

package prefix_pkg;

	// Group generate and propagate for one span of bits
	typedef struct packed {
		logic g;
		logic p;
	} gp_t;

	// Leaf of the tree, built from one pair of operand bits
	function automatic gp_t leaf_cell(input logic a_bit, input logic b_bit);
		gp_t leaf;
		leaf.g = a_bit & b_bit;
		leaf.p = a_bit ^ b_bit;
		return leaf;
	endfunction

	// Merge an upper span with the span just below it
	function automatic gp_t black_cell(input gp_t upper, input gp_t lower);
		gp_t merged;
		merged.p = upper.p & lower.p;
		merged.g = upper.g | (upper.p & lower.g);
		return merged;
	endfunction

	// Span reaches bit 0, so only the generate is needed
	function automatic logic grey_cell(input gp_t upper, input gp_t lower);
		logic carry_out;
		carry_out = upper.g | (upper.p & lower.g);
		return carry_out;
	endfunction

endpackage

`default_nettype wire

//--- src.f
logic/prefix_pkg.sv
logic/alu_pkg.sv
logic/pipe_stage.sv
logic/ladner_fischer.sv
logic/adder.sv
logic/add_unit_top.sv
verification/add_unit_asserts.sv
verification/add_unit_tb.sv

//--- verification/add_unit_asserts.sv
// Adder unit timing assertions
`timescale 1ns/1ns
`default_nettype none

module add_unit_asserts (
	input logic              clk,
	input logic              rst,
	input logic              in_valid,
	input logic              out_valid,
	input alu_pkg::add_res_t out_res
);

	// Number of failed assertions
	int fail_count = 0;

	// Reset clears the output strobe on the next cycle
	a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid still high one cycle after reset");
		end

	// Request stage was cleared too, so the second cycle after reset is empty
	a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		$past(rst, 2) |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high in the second cycle after reset");
		end

	// Two-cycle latency once the pipe has refilled
	a_latency: assert property (@(posedge clk) disable iff (rst)
		(!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(in_valid, 2)))
		else begin
			fail_count++;
			$error("out_valid does not follow in_valid by two cycles");
		end

	// A presented result is fully known
	a_known: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_res))
		else begin
			fail_count++;
			$error("out_res has unknown bits while out_valid is high");
		end

endmodule

`default_nettype wire

//--- verification/add_unit_tb.sv
// Significand adder unit testbench
`timescale 1ns/1ns
`default_nettype none

module add_unit_tb;

	localparam int WIDTH = alu_pkg::WIDTH_DEFAULT;
	localparam int RANDOM_COUNT = 200;
	localparam int DRAIN_LIMIT = 20;

	// Expected result and the cycle it has to appear in
	typedef struct packed {
		alu_pkg::add_res_t res;
		logic [31:0]       due;
		logic [31:0]       tag;
	} pending_t;

	logic              clk = 1'b0;
	logic              rst;
	logic              in_valid;
	alu_pkg::add_req_t in_req;
	logic              out_valid;
	alu_pkg::add_res_t out_res;

	pending_t    pending_q[$];
	int          cycle_cnt = 0;
	int          checks = 0;
	int          errors = 0;
	int          dropped = 0;
	logic        timed_out = 1'b0;
	logic [31:0] rng_state = 32'hb0d70b73;

	add_unit_top #(
		.WIDTH(WIDTH)
	) dut_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_req   (in_req),
		.out_valid(out_valid),
		.out_res  (out_res)
	);

	bind add_unit_top add_unit_asserts asserts_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.out_valid(out_valid),
		.out_res  (out_res)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Plain integer sum on WIDTH+1 bits
	function automatic alu_pkg::add_res_t model_result(input alu_pkg::add_req_t req);
		logic [WIDTH-1:0]  b_eff;
		logic              c_eff;
		logic [WIDTH:0]    full;
		alu_pkg::add_res_t res;
		b_eff = req.b;
		c_eff = 1'b0;
		if (req.op == alu_pkg::OP_SUB) begin
			b_eff = ~req.b;
			c_eff = 1'b1;
		end else if (req.op == alu_pkg::OP_ADC) begin
			c_eff = req.cin;
		end
		full = {1'b0, req.a} + {1'b0, b_eff} + {{WIDTH{1'b0}}, c_eff};
		res.sum = full[WIDTH-1:0];
		res.cout = full[WIDTH];
		res.zero = (full[WIDTH-1:0] == '0);
		res.negative = full[WIDTH-1];
		// Operand signs agree but the result sign does not
		res.overflow = (req.a[WIDTH-1] == b_eff[WIDTH-1]) && (full[WIDTH-1] != req.a[WIDTH-1]);
		return res;
	endfunction

	task automatic send(input alu_pkg::add_req_t req, input alu_pkg::add_res_t exp_res,
		input int tag);
		pending_t entry;
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		in_req = req;
		entry.res = exp_res;
		entry.due = cycle_cnt + 2;
		entry.tag = tag;
		pending_q.push_back(entry);
	endtask

	task automatic idle();
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic drain(input string what);
		int waited;
		waited = 0;
		while (pending_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (pending_q.size() != 0) begin
			$display("Timeout after %0d cycles waiting for %0d %s results", waited,
				pending_q.size(), what);
			timed_out = 1'b1;
		end
	endtask

	task automatic play_file_vectors();
		int                fd;
		int                rc;
		int                fields;
		int                tag;
		string             line;
		logic [1:0]        op_v;
		logic [31:0]       a_v;
		logic [31:0]       b_v;
		logic [31:0]       sum_v;
		logic              cin_v;
		logic              cout_v;
		logic              zero_v;
		logic              neg_v;
		logic              ovf_v;
		alu_pkg::add_req_t req;
		alu_pkg::add_res_t res;
		tag = 0;
		fd = $fopen("verification/add_unit_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/add_unit_tests.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc == 0 || line.len() == 0 || line[0] == "#") begin
					continue;
				end
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op_v, a_v, b_v, cin_v,
					sum_v, cout_v, zero_v, neg_v, ovf_v);
				if (fields == 9) begin
					req.op = alu_pkg::op_t'(op_v);
					req.a = a_v[WIDTH-1:0];
					req.b = b_v[WIDTH-1:0];
					req.cin = cin_v;
					res.sum = sum_v[WIDTH-1:0];
					res.cout = cout_v;
					res.zero = zero_v;
					res.negative = neg_v;
					res.overflow = ovf_v;
					send(req, res, tag);
					tag++;
				end
			end
			$fclose(fd);
			idle();
		end
	endtask

	// Back-to-back requests, some with equal operands
	task automatic random_burst(input int count, input int tag_base);
		logic [31:0]       r;
		logic [31:0]       r_a;
		logic [31:0]       r_b;
		alu_pkg::add_req_t req;
		for (int n = 0; n < count; n++) begin
			r = next_random();
			r_a = next_random();
			r_b = next_random();
			req.op = alu_pkg::op_t'(r[1:0]);
			req.cin = r[2];
			req.a = r_a[WIDTH-1:0];
			req.b = (r[7:4] == 4'h0) ? r_a[WIDTH-1:0] : r_b[WIDTH-1:0];
			send(req, model_result(req), tag_base + n);
		end
	endtask

	// Reset lands while two requests are inside the pipe
	task automatic reset_mid_stream(input int tag_base);
		int                flushed;
		logic [31:0]       r;
		alu_pkg::add_req_t req;
		random_burst(5, tag_base);
		r = next_random();
		req = '{op: alu_pkg::OP_ADD, a: r[WIDTH-1:0], b: r[31:4], cin: 1'b0};
		send(req, model_result(req), tag_base + 5);
		rst = 1'b1;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		flushed = pending_q.size();
		dropped += flushed;
		pending_q.delete();
		assert (flushed == 2) else begin
			$display("Fail at %0t: %0d requests flushed by reset, expected 2", $time, flushed);
			errors++;
		end
		@(negedge clk);
		assert (!out_valid) else begin
			$display("Fail at %0t: out_valid high while reset is asserted", $time);
			errors++;
		end
		@(posedge clk);
		#2;
		rst = 1'b0;
		random_burst(6, tag_base + 100);
		idle();
	endtask

	task automatic report(input string name, input int base_checks, input int base_errors);
		$display("Test %s: %0d results checked, %0d errors", name, checks - base_checks,
			errors - base_errors);
	endtask

	// Compare each presented result with the oldest expected one
	always @(negedge clk) begin
		pending_t entry;
		if (out_valid) begin
			if (pending_q.size() == 0) begin
				$display("Result presented at %0t with no request outstanding", $time);
				errors++;
			end else begin
				entry = pending_q.pop_front();
				checks++;
				assert (cycle_cnt == int'(entry.due)) else begin
					$display("Fail at %0t: vector %0d arrived in cycle %0d, expected cycle %0d",
						$time, entry.tag, cycle_cnt, entry.due);
					errors++;
				end
				assert (out_res.sum == entry.res.sum) else begin
					$display("Fail at %0t: vector %0d sum %h, expected %h", $time, entry.tag,
						out_res.sum, entry.res.sum);
					errors++;
				end
				// Flag order is cout zero negative overflow
				assert ({out_res.cout, out_res.zero, out_res.negative, out_res.overflow} ==
					{entry.res.cout, entry.res.zero, entry.res.negative, entry.res.overflow})
				else begin
					$display("Fail at %0t: vector %0d flags %b%b%b%b, expected %b%b%b%b",
						$time, entry.tag, out_res.cout, out_res.zero, out_res.negative,
						out_res.overflow, entry.res.cout, entry.res.zero, entry.res.negative,
						entry.res.overflow);
					errors++;
				end
			end
		end
	end

	initial begin
		int base_checks;
		int base_errors;
		rst = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		base_checks = checks;
		base_errors = errors;
		play_file_vectors();
		drain("file vector");
		report("file vectors", base_checks, base_errors);

		if (!timed_out) begin
			base_checks = checks;
			base_errors = errors;
			random_burst(RANDOM_COUNT, 1000);
			idle();
			drain("random");
			report("random back-to-back", base_checks, base_errors);
		end

		if (!timed_out) begin
			base_checks = checks;
			base_errors = errors;
			reset_mid_stream(2000);
			drain("post-reset");
			report("mid-stream reset", base_checks, base_errors);
		end

		// Concurrent assertion failures count as errors too
		errors += dut_i.asserts_i.fail_count;
		$display("Totals: %0d results checked, %0d errors, %0d requests dropped by reset",
			checks, errors, dropped);
		if (!timed_out && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/add_unit_tests.txt
# op a b cin sum cout zero negative overflow, all in hex
# op: 0 add, 1 subtract, 2 add with carry-in, 3 reserved (runs as add)
0 0000001 0000002 0 0000003 0 0 0 0
0 FFFFFFF 0000001 0 0000000 1 1 0 0
0 8000000 8000000 0 0000000 1 1 0 1
0 7FFFFFF 0000001 0 8000000 0 0 1 1
0 1234567 0FEDCBA 1 2222221 0 0 0 0
0 5555555 AAAAAAA 0 FFFFFFF 0 0 1 0
1 0000005 0000003 0 0000002 1 0 0 0
1 00ABCDE 00ABCDE 0 0000000 1 1 0 0
1 0000000 0000000 1 0000000 1 1 0 0
1 0000003 0000005 0 FFFFFFE 0 0 1 0
1 8000000 0000001 0 7FFFFFF 1 0 0 1
1 7FFFFFF FFFFFFF 0 8000000 0 0 1 1
2 0000010 0000020 1 0000031 0 0 0 0
2 0000010 0000020 0 0000030 0 0 0 0
2 FFFFFFF 0000000 1 0000000 1 1 0 0
2 7FFFFFF 0000000 1 8000000 0 0 1 1
3 0000004 0000004 1 0000008 0 0 0 0
